// File: common/adc_rx_pkg.sv
// ADC receive path definitions
package adc_rx_pkg;

    // width of one I or Q lane
    localparam int iq_width = 16;

    // one I/Q pair packed into a single word
    localparam int sample_width = 2 * iq_width;

    // sample FIFO geometry
    localparam int fifo_depth = 32;
    localparam int fifo_addr_width = $clog2(fifo_depth);

    // baseband gain control
    localparam int gain_width = 3;

    // codes above this one leave the sample untouched
    localparam logic [gain_width-1:0] gain_max_shift = 3'd4;

    // the same word is seen as one raw word or as two signed lanes
    // q sits in the upper half, i in the lower half
    typedef union packed {
        logic [sample_width-1:0] raw;
        struct packed {
            logic [iq_width-1:0] q;
            logic [iq_width-1:0] i;
        } lane;
    } iq_sample_t;

endpackage

// File: src/adc_decimator.sv
// ADC decimate-by-two stage
`timescale 1ns/1ps

module adc_decimator (
    input  logic                   adc_clk,
    input  logic                   adc_rst,
    input  adc_rx_pkg::iq_sample_t adc_data,
    input  logic                   adc_valid,
    output adc_rx_pkg::iq_sample_t wr_data,
    output logic                   wr_en
);

    // high once an odd number of valid samples has been seen
    logic phase;

    // phase counts valid cycles only, idle cycles leave it alone
    always_ff @(posedge adc_clk) begin
        if (adc_rst) begin
            phase <= 1'b0;
        end else if (adc_valid) begin
            phase <= ~phase;
        end
    end

    // every second valid sample is written one cycle later
    always_ff @(posedge adc_clk) begin
        if (adc_rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= adc_valid & phase;
        end
    end

    // the sample register follows the input on every cycle
    always_ff @(posedge adc_clk) begin
        wr_data <= adc_data;
    end

endmodule

// File: cdc_fifo/cdc_fifo.sv
// dual-clock first-word-fall-through FIFO
`timescale 1ns/1ps

module cdc_fifo (
    input  logic                   adc_clk,
    input  logic                   adc_rst,
    input  logic                   wr_en,
    input  adc_rx_pkg::iq_sample_t wr_data,
    input  logic                   acc_clk,
    input  logic                   acc_rstn,
    input  logic                   rd_en,
    output adc_rx_pkg::iq_sample_t rd_data,
    output logic                   empty_n
);

    adc_rx_pkg::iq_sample_t mem [adc_rx_pkg::fifo_depth];

    // pointers carry one extra bit to tell full from empty
    logic [adc_rx_pkg::fifo_addr_width:0] wr_bin;
    logic [adc_rx_pkg::fifo_addr_width:0] wr_bin_next;
    logic [adc_rx_pkg::fifo_addr_width:0] wr_gray;
    logic [adc_rx_pkg::fifo_addr_width:0] rd_bin;
    logic [adc_rx_pkg::fifo_addr_width:0] rd_bin_next;
    logic [adc_rx_pkg::fifo_addr_width:0] rd_gray;

    // Gray pointers after crossing into the other domain
    logic [adc_rx_pkg::fifo_addr_width:0] rd_gray_meta;
    logic [adc_rx_pkg::fifo_addr_width:0] rd_gray_wsync;
    logic [adc_rx_pkg::fifo_addr_width:0] wr_gray_meta;
    logic [adc_rx_pkg::fifo_addr_width:0] wr_gray_rsync;

    logic acc_rstn_meta;
    logic acc_rstn_wsync;
    logic wr_clear;
    logic full;
    logic wr_push;
    logic rd_pop;

    // an accelerator reset must also empty the write side
    always_ff @(posedge adc_clk) begin
        acc_rstn_meta  <= acc_rstn;
        acc_rstn_wsync <= acc_rstn_meta;
    end

    assign wr_clear = adc_rst | ~acc_rstn_wsync;

    // full when the write pointer is one whole pass ahead of the read pointer
    assign full = (wr_gray == {~rd_gray_wsync[adc_rx_pkg::fifo_addr_width -: 2],
                               rd_gray_wsync[adc_rx_pkg::fifo_addr_width-2:0]});

    // writes into a full FIFO are simply lost
    assign wr_push     = wr_en & ~full;
    assign wr_bin_next = wr_bin + {{adc_rx_pkg::fifo_addr_width{1'b0}}, wr_push};

    always_ff @(posedge adc_clk) begin
        if (wr_clear) begin
            wr_bin        <= '0;
            wr_gray       <= '0;
            rd_gray_meta  <= '0;
            rd_gray_wsync <= '0;
        end else begin
            wr_bin        <= wr_bin_next;
            wr_gray       <= wr_bin_next ^ (wr_bin_next >> 1);
            rd_gray_meta  <= rd_gray;
            rd_gray_wsync <= rd_gray_meta;
        end
    end

    always_ff @(posedge adc_clk) begin
        if (wr_push) begin
            mem[wr_bin[adc_rx_pkg::fifo_addr_width-1:0]] <= wr_data;
        end
    end

    // empty is judged against the synchronized write pointer
    assign empty_n     = (rd_gray != wr_gray_rsync);
    assign rd_pop      = rd_en & empty_n;
    assign rd_bin_next = rd_bin + {{adc_rx_pkg::fifo_addr_width{1'b0}}, rd_pop};

    always_ff @(posedge acc_clk) begin
        if (!acc_rstn) begin
            rd_bin        <= '0;
            rd_gray       <= '0;
            wr_gray_meta  <= '0;
            wr_gray_rsync <= '0;
        end else begin
            rd_bin        <= rd_bin_next;
            rd_gray       <= rd_bin_next ^ (rd_bin_next >> 1);
            wr_gray_meta  <= wr_gray;
            wr_gray_rsync <= wr_gray_meta;
        end
    end

    // the head word is always on the output, valid while empty_n is high
    assign rd_data = mem[rd_bin[adc_rx_pkg::fifo_addr_width-1:0]];

endmodule

// File: src/iq_gain_shift.sv
// baseband gain shifter
`timescale 1ns/1ps

module iq_gain_shift (
    input  adc_rx_pkg::iq_sample_t          sample,
    input  logic [adc_rx_pkg::gain_width-1:0] bb_gain,
    output adc_rx_pkg::iq_sample_t          data_to_acc
);

    // bits shifted out at the top are dropped, there is no saturation
    function automatic logic [adc_rx_pkg::iq_width-1:0] lane_shift(
        input logic [adc_rx_pkg::iq_width-1:0]   lane,
        input logic [adc_rx_pkg::gain_width-1:0] code
    );
        logic [adc_rx_pkg::iq_width-1:0] shifted;
        shifted = lane << code;
        return shifted;
    endfunction

    always_comb begin
        data_to_acc.raw = sample.raw;
        // I and Q are shifted separately so no bit crosses between lanes
        if (bb_gain <= adc_rx_pkg::gain_max_shift) begin
            data_to_acc.lane.i = lane_shift(sample.lane.i, bb_gain);
            data_to_acc.lane.q = lane_shift(sample.lane.q, bb_gain);
        end
    end

endmodule

// File: src/adc_rx_intf.sv
// ADC receive interface top
`timescale 1ns/1ps

module adc_rx_intf (
    input  logic                              adc_clk,
    input  logic                              adc_rst,
    input  logic [adc_rx_pkg::sample_width-1:0] adc_data,
    input  logic                              adc_valid,
    input  logic                              acc_clk,
    input  logic                              acc_rstn,
    input  logic [adc_rx_pkg::gain_width-1:0]   bb_gain,
    input  logic                              acc_ask_data,
    output logic [adc_rx_pkg::sample_width-1:0] data_to_acc,
    output logic                              emptyn_to_acc
);

    // kept samples on their way into the FIFO
    adc_rx_pkg::iq_sample_t wr_data;
    logic                   wr_en;

    // head of the FIFO in the accelerator domain
    adc_rx_pkg::iq_sample_t rd_data;

    // halve the ADC rate
    adc_decimator decim0 (
        .adc_clk   (adc_clk),
        .adc_rst   (adc_rst),
        .adc_data  (adc_data),
        .adc_valid (adc_valid),
        .wr_data   (wr_data),
        .wr_en     (wr_en)
    );

    // cross from adc_clk to acc_clk
    cdc_fifo fifo0 (
        .adc_clk  (adc_clk),
        .adc_rst  (adc_rst),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .acc_clk  (acc_clk),
        .acc_rstn (acc_rstn),
        .rd_en    (acc_ask_data),
        .rd_data  (rd_data),
        .empty_n  (emptyn_to_acc)
    );

    // gain is applied after the crossing, so a new code acts at once
    iq_gain_shift gain0 (
        .sample      (rd_data),
        .bb_gain     (bb_gain),
        .data_to_acc (data_to_acc)
    );

endmodule

// File: dv/adc_rx_assert.sv
// ADC receive output protocol checks
`timescale 1ns/1ps

module adc_rx_assert (
    input logic                                acc_clk,
    input logic                                acc_rstn,
    input logic [adc_rx_pkg::gain_width-1:0]   bb_gain,
    input logic                                acc_ask_data,
    input logic [adc_rx_pkg::sample_width-1:0] data_to_acc,
    input logic                                emptyn_to_acc
);

    // a reset cycle clears both read side pointers
    property empty_in_reset;
        @(posedge acc_clk) !acc_rstn |=> !emptyn_to_acc;
    endproperty

    property data_known;
        @(posedge acc_clk) disable iff (!acc_rstn)
            emptyn_to_acc |-> !$isunknown(data_to_acc);
    endproperty

    // without a pop the head word only changes through a new gain code
    property data_held;
        @(posedge acc_clk) disable iff (!acc_rstn)
            (emptyn_to_acc && !acc_ask_data) |=>
                ((data_to_acc == $past(data_to_acc)) || (bb_gain != $past(bb_gain)));
    endproperty

    empty_in_reset_a: assert property (empty_in_reset)
        else $error("emptyn_to_acc high after an acc_rstn cycle");

    data_known_a: assert property (data_known)
        else $error("data_to_acc unknown while emptyn_to_acc is high");

    data_held_a: assert property (data_held)
        else $error("data_to_acc changed without a read or a gain change");

endmodule

bind adc_rx_intf adc_rx_assert assert0 (
    .acc_clk       (acc_clk),
    .acc_rstn      (acc_rstn),
    .bb_gain       (bb_gain),
    .acc_ask_data  (acc_ask_data),
    .data_to_acc   (data_to_acc),
    .emptyn_to_acc (emptyn_to_acc)
);

// File: dv/tb_adc_rx.sv
// ADC receive interface testbench
`timescale 1ns/1ps

module tb_adc_rx;

    logic                                adc_clk;
    logic                                adc_rst;
    logic [adc_rx_pkg::sample_width-1:0] adc_data;
    logic                                adc_valid;
    logic                                acc_clk;
    logic                                acc_rstn;
    logic [adc_rx_pkg::gain_width-1:0]   bb_gain;
    logic                                acc_ask_data;
    logic [adc_rx_pkg::sample_width-1:0] data_to_acc;
    logic                                emptyn_to_acc;

    // one entry per line of the vector file
    int                                  vec_phase[$];
    logic [adc_rx_pkg::sample_width-1:0] vec_in[$];
    logic [adc_rx_pkg::gain_width-1:0]   vec_gain[$];
    logic                                vec_kept[$];
    logic [adc_rx_pkg::sample_width-1:0] vec_out[$];

    int seed;
    int mismatch_count;
    int other_count;

    adc_rx_intf dut0 (
        .adc_clk       (adc_clk),
        .adc_rst       (adc_rst),
        .adc_data      (adc_data),
        .adc_valid     (adc_valid),
        .acc_clk       (acc_clk),
        .acc_rstn      (acc_rstn),
        .bb_gain       (bb_gain),
        .acc_ask_data  (acc_ask_data),
        .data_to_acc   (data_to_acc),
        .emptyn_to_acc (emptyn_to_acc)
    );

    initial begin
        acc_clk = 1'b0;
        forever #2 acc_clk = ~acc_clk;
    end

    // the ADC clock has no fixed relation to acc_clk
    initial begin
        adc_clk = 1'b0;
        forever #5 adc_clk = ~adc_clk;
    end

    task automatic load_vectors();
        int          fd;
        int          n;
        int          ph;
        int          gc;
        logic [31:0] din;
        logic [31:0] dout;
        string       line;
        string       exp_txt;
        fd = $fopen("dv/adc_rx_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file dv/adc_rx_vectors.txt");
            other_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%d %h %d %s", ph, din, gc, exp_txt);
                if (n == 4) begin
                    dout = '0;
                    vec_phase.push_back(ph);
                    vec_in.push_back(din);
                    vec_gain.push_back(gc[2:0]);
                    vec_kept.push_back(exp_txt != "-");
                    if (exp_txt != "-") begin
                        n = $sscanf(exp_txt, "%h", dout);
                    end
                    vec_out.push_back(dout);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic collect_phase(input int ph, output int idx[$]);
        idx = {};
        foreach (vec_phase[k]) begin
            if (vec_phase[k] == ph) begin
                idx.push_back(k);
            end
        end
    endtask

    task automatic drive_sample(input int k);
        @(posedge adc_clk);
        #1;
        adc_data  = vec_in[k];
        adc_valid = 1'b1;
    endtask

    // idle cycles carry junk data that must never be counted
    task automatic idle_adc(input int cycles);
        repeat (cycles) begin
            @(posedge adc_clk);
            #1;
            adc_valid = 1'b0;
            adc_data  = $random(seed);
        end
    endtask

    task automatic feed_list(input int idx[$], input bit gaps);
        int gap;
        foreach (idx[n]) begin
            drive_sample(idx[n]);
            if (gaps) begin
                gap = $unsigned($random(seed)) % 3;
                idle_adc(gap);
            end
        end
        idle_adc(1);
    endtask

    task automatic read_word(input int k);
        int waited;
        waited = 0;
        @(posedge acc_clk);
        #1;
        while (!emptyn_to_acc && waited < 200) begin
            @(posedge acc_clk);
            #1;
            waited++;
        end
        if (!emptyn_to_acc) begin
            $display("timeout at %0t: no word arrived for vector line %0d", $time, k);
            other_count++;
            return;
        end
        bb_gain = vec_gain[k];
        @(negedge acc_clk);
        if (data_to_acc !== vec_out[k]) begin
            $display("FAILED at %0t: data_to_acc expected %h, got %h (vector line %0d)",
                     $time, vec_out[k], data_to_acc, k);
            mismatch_count++;
        end
        @(posedge acc_clk);
        #1;
        acc_ask_data = 1'b1;
        @(posedge acc_clk);
        #1;
        acc_ask_data = 1'b0;
    endtask

    task automatic read_list(input int idx[$], input int max_words);
        int count;
        count = 0;
        foreach (idx[n]) begin
            if (vec_kept[idx[n]] && count < max_words) begin
                read_word(idx[n]);
                count++;
            end
        end
    endtask

    task automatic watch_low(input int cycles);
        repeat (cycles) begin
            @(posedge acc_clk);
            #1;
            if (emptyn_to_acc !== 1'b0) begin
                $display("FAILED at %0t: emptyn_to_acc expected 0, got %b",
                         $time, emptyn_to_acc);
                mismatch_count++;
                return;
            end
        end
    endtask

    task automatic wait_empty();
        int waited;
        waited = 0;
        @(posedge acc_clk);
        #1;
        while (emptyn_to_acc && waited < 200) begin
            @(posedge acc_clk);
            #1;
            waited++;
        end
        if (emptyn_to_acc) begin
            $display("timeout at %0t: emptyn_to_acc never fell after the last read", $time);
            other_count++;
        end
    endtask

    initial begin
        int p1[$];
        int p2[$];
        int p3[$];
        int p4[$];
        int p5[$];
        seed           = 27189;
        mismatch_count = 0;
        other_count    = 0;
        adc_rst        = 1'b1;
        acc_rstn       = 1'b0;
        adc_data       = '0;
        adc_valid      = 1'b0;
        bb_gain        = '0;
        acc_ask_data   = 1'b0;

        load_vectors();
        collect_phase(1, p1);
        collect_phase(2, p2);
        collect_phase(3, p3);
        collect_phase(4, p4);
        if (other_count == 0 && (p1.size() != 2 || p2.size() != 20 ||
                                 p3.size() != 16 || p4.size() != 40)) begin
            $display("the vector file does not hold the expected lines per phase");
            other_count++;
        end

        repeat (8) @(posedge acc_clk);
        #1;
        acc_rstn = 1'b1;
        @(posedge adc_clk);
        #1;
        adc_rst = 1'b0;
        // give the write side time to see acc_rstn released
        idle_adc(4);

        if (other_count == 0) begin
            // a single valid sample must not reach the accelerator
            watch_low(1);
            drive_sample(p1[0]);
            idle_adc(1);
            watch_low(20);
            drive_sample(p1[1]);
            idle_adc(1);
            read_word(p1[1]);
            wait_empty();

            // back to back decimation with the reader running
            fork
                feed_list(p2, 1'b0);
                read_list(p2, 1000);
            join
            wait_empty();

            fork
                feed_list(p3, 1'b1);
                read_list(p3, 1000);
            join
            wait_empty();

            // 20 kept words fit, reads start once feeding is over
            feed_list(p4, 1'b1);
            idle_adc(6);
            read_list(p4, 1000);
            wait_empty();

            // phase 4 twice over gives 40 kept words and only the first 32 fit
            p5 = {p4, p4};
            feed_list(p5, 1'b1);
            idle_adc(6);
            read_list(p5, adc_rx_pkg::fifo_depth);
            // the 8 dropped words must never show up after the last read
            watch_low(40);
        end

        $display("run complete: %0d value mismatches, %0d other failures",
                 mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: dv/adc_rx_vectors.txt
# columns: phase, input word in hex (q upper half, i lower half), gain code,
# expected data_to_acc in hex for a kept sample, or - where the sample is dropped
1 0badf00d 0 -
1 12345678 0 12345678
2 a0010001 0 -
2 a0020002 0 a0020002
2 a0030003 0 -
2 a0040004 0 a0040004
2 a0050005 0 -
2 a0060006 0 a0060006
2 a0070007 0 -
2 a0080008 0 a0080008
2 a0090009 0 -
2 a00a000a 0 a00a000a
2 a00b000b 0 -
2 a00c000c 0 a00c000c
2 a00d000d 0 -
2 a00e000e 0 a00e000e
2 a00f000f 0 -
2 a0100010 0 a0100010
2 a0110011 0 -
2 a0120012 0 a0120012
2 a0130013 0 -
2 a0140014 0 a0140014
3 5555aaaa 0 -
3 80017fff 0 80017fff
3 0f0f0f0f 0 -
3 fffe4001 1 fffc8002
3 13572468 0 -
3 8765c003 2 1d94000c
3 7e7e8181 0 -
3 ffff1234 3 fff891a0
3 00ff00ff 0 -
3 84210fed 4 4210fed0
3 3c3cc3c3 0 -
3 9abcdef0 5 9abcdef0
3 1111eeee 0 -
3 8000ffff 6 8000ffff
3 2468ace0 0 -
3 7fff8001 7 7fff8001
4 c4013b01 0 -
4 c4023b02 0 c4023b02
4 c4033b03 0 -
4 c4043b04 5 c4043b04
4 c4053b05 0 -
4 c4063b06 6 c4063b06
4 c4073b07 0 -
4 c4083b08 7 c4083b08
4 c4093b09 0 -
4 c40a3b0a 0 c40a3b0a
4 c40b3b0b 0 -
4 c40c3b0c 5 c40c3b0c
4 c40d3b0d 0 -
4 c40e3b0e 6 c40e3b0e
4 c40f3b0f 0 -
4 c4103b10 7 c4103b10
4 c4113b11 0 -
4 c4123b12 0 c4123b12
4 c4133b13 0 -
4 c4143b14 5 c4143b14
4 c4153b15 0 -
4 c4163b16 6 c4163b16
4 c4173b17 0 -
4 c4183b18 7 c4183b18
4 c4193b19 0 -
4 c41a3b1a 0 c41a3b1a
4 c41b3b1b 0 -
4 c41c3b1c 5 c41c3b1c
4 c41d3b1d 0 -
4 c41e3b1e 6 c41e3b1e
4 c41f3b1f 0 -
4 c4203b20 7 c4203b20
4 c4213b21 0 -
4 c4223b22 0 c4223b22
4 c4233b23 0 -
4 c4243b24 5 c4243b24
4 c4253b25 0 -
4 c4263b26 6 c4263b26
4 c4273b27 0 -
4 c4283b28 7 c4283b28

// File: tb.f
common/adc_rx_pkg.sv
src/adc_decimator.sv
cdc_fifo/cdc_fifo.sv
src/iq_gain_shift.sv
src/adc_rx_intf.sv
dv/adc_rx_assert.sv
dv/tb_adc_rx.sv

// File: Makefile
# Verilator flow for the ADC receive interface

TOP := tb_adc_rx

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

# the run fails on a nonzero simulator status or on the fail message in sim.log
sim:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ]; then \
		echo "simulator exited with status $$status"; \
		exit 1; \
	fi
	@if grep -q "tests failed" sim.log; then \
		echo "failure found in sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
